// ==== hw/ucs_pkg.sv ====
// Shared widths, buffer depth, APB register map and types for the unsat-clause selector
package ucs_pkg;

    // Buffer geometry, sized so that a full count of 32 still fits the count width
    localparam int BUF_DEPTH = 32;
    localparam int SLOT_W = 5;
    localparam int COUNT_W = 6;

    // Payload widths
    localparam int CLAUSE_W = 12;
    localparam int RAND_W = 16;
    localparam int RECIP_W = 32;
    localparam int APB_ADDR_W = 8;
    localparam int APB_DATA_W = 32;

    // Cycles from a selection request to a slot index at the mapper output
    localparam int MAP_LATENCY = 3;

    // Reciprocal table image, relative to the project root
    localparam string RECIP_FILE = "hw/recip_table.mem";

    typedef logic [CLAUSE_W-1:0]   clause_id_t;
    typedef logic [RAND_W-1:0]     rand_t;
    typedef logic [RECIP_W-1:0]    recip_t;
    typedef logic [SLOT_W-1:0]     slot_t;
    typedef logic [COUNT_W-1:0]    count_t;
    typedef logic [APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [APB_DATA_W-1:0] apb_data_t;

    // APB register offsets
    localparam apb_addr_t REG_CTRL = 8'h00;
    localparam apb_addr_t REG_PUSH = 8'h04;
    localparam apb_addr_t REG_SELECT = 8'h08;
    localparam apb_addr_t REG_STATUS = 8'h0C;
    localparam apb_addr_t REG_RESULT = 8'h10;

    // One selection request into the mapper, with the fill count captured at issue
    typedef struct packed {
        rand_t  rnd;
        count_t count;
    } sel_req_t;

endpackage

// ==== hw/recip_table.sv ====
// Reciprocal ROM for the modulo mapper, holding ceil(2^32 / m) for m = 1..32
// Flags a sticky divide-by-zero when a lookup is made with a count of zero
`timescale 1ns/100ps

module recip_table import ucs_pkg::*; (
    input  logic   clk_i,
    input  logic   reset_i,
    input  logic   en_i,
    input  count_t count_i,
    input  logic   clear_div_zero_i,
    output recip_t recip_o,
    output logic   div_zero_o
);

    // Entry i holds the rounded-up fraction 1/(i+1) with all 32 bits fractional
    // Entry 0 would need 2^32, which saturates to all ones in the image
    recip_t rom [BUF_DEPTH];
    slot_t  rom_addr;

    initial begin
        $readmemh(RECIP_FILE, rom);
    end

    // Count m lives at entry m-1, and a zero count falls back to entry 0
    always_comb begin
        if (count_i == '0) begin
            rom_addr = '0;
        end else begin
            rom_addr = slot_t'(count_i - count_t'(1));
        end
    end

    // Registered lookup that returns zero whenever no request is presented
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            recip_o <= rom[rom_addr];
        end else begin
            recip_o <= '0;
        end
    end

    // Sticky flag, where a new zero-count lookup wins over a clear in the same cycle
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            div_zero_o <= 1'b0;
        end else if (en_i && count_i == '0) begin
            div_zero_o <= 1'b1;
        end else if (clear_div_zero_i) begin
            div_zero_o <= 1'b0;
        end
    end

endmodule

// ==== hw/unsat_buffer.sv ====
// Unsatisfied clause buffer, filled in order by pushes and read back by slot index
`timescale 1ns/100ps

module unsat_buffer import ucs_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       push_i,
    input  clause_id_t push_id_i,
    input  logic       clear_i,
    input  logic       rd_en_i,
    input  slot_t      rd_slot_i,
    output clause_id_t rd_id_o,
    output logic       rd_valid_o,
    output count_t     count_o,
    output logic       full_o
);

    clause_id_t mem [BUF_DEPTH];
    count_t     count_q;
    logic       push_ok;

    assign full_o = (count_q == count_t'(BUF_DEPTH));
    assign count_o = count_q;

    // A push into a full buffer is dropped here
    // The register block has already answered it with an error
    assign push_ok = push_i && !full_o;

    // The next free slot is always the current count
    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            mem[slot_t'(count_q)] <= push_id_i;
        end
    end

    // Fill level, where clear takes priority over a push in the same cycle
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            count_q <= '0;
        end else if (clear_i) begin
            count_q <= '0;
        end else if (push_ok) begin
            count_q <= count_q + count_t'(1);
        end
    end

    // Registered read port, with the valid bit following the enable by one cycle
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_id_o <= mem[rd_slot_i];
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= rd_en_i;
        end
    end

endmodule

// ==== hw/index_mapper.sv ====
// Three-stage pipeline computing rnd mod count with a reciprocal multiply
// Stage 1 reads the table, stage 2 forms the quotient and stage 3 the remainder
`timescale 1ns/100ps

module index_mapper import ucs_pkg::*; (
    input  logic     clk_i,
    input  logic     reset_i,
    input  logic     start_i,
    input  sel_req_t req_i,
    output logic     recip_en_o,
    output count_t   recip_count_o,
    input  recip_t   recip_i,
    output logic     slot_valid_o,
    output slot_t    slot_o
);

    logic                   s1_valid;
    sel_req_t               s1_req;
    logic                   s2_valid;
    sel_req_t               s2_req;
    rand_t                  s2_quot;
    logic [RAND_W+RECIP_W-1:0] product;
    logic [RAND_W+COUNT_W-1:0] quot_times_count;
    logic [RAND_W+COUNT_W:0]   rem_raw;
    logic [RAND_W+COUNT_W:0]   rem_fix;
    logic [RAND_W+COUNT_W:0]   count_ext;

    // Stage 1 presents the count to the table, whose registered output lines up with s1
    assign recip_en_o = start_i;
    assign recip_count_o = req_i.count;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= start_i;
            s2_valid <= s1_valid;
        end
    end

    // Stage 2 keeps the upper 16 bits of rnd times the 0.32 reciprocal
    assign product = s1_req.rnd * recip_i;

    always_ff @(posedge clk_i) begin
        s1_req <= req_i;
        s2_req <= s1_req;
        s2_quot <= product[RAND_W+RECIP_W-1:RECIP_W];
    end

    // Stage 3 takes the remainder in a signed-wide form
    // The rounded-up reciprocal can overshoot the quotient, which shows as a negative value
    // The saturated entry for a count of one undershoots, which the upper check repairs
    assign quot_times_count = s2_quot * s2_req.count;
    assign count_ext = {{(RAND_W+1){1'b0}}, s2_req.count};
    assign rem_raw = {{(COUNT_W+1){1'b0}}, s2_req.rnd} - {1'b0, quot_times_count};

    always_comb begin
        if (rem_raw[RAND_W+COUNT_W]) begin
            rem_fix = rem_raw + count_ext;
        end else if (rem_raw >= count_ext) begin
            rem_fix = rem_raw - count_ext;
        end else begin
            rem_fix = rem_raw;
        end
    end

    // An empty buffer has no slot to read, so the request dies here
    assign slot_valid_o = s2_valid && (s2_req.count != '0);
    assign slot_o = rem_fix[SLOT_W-1:0];

endmodule

// ==== hw/apb_regs.sv ====
// APB slave register block that issues pushes, clears and selections
// Tracks the selection in flight and holds the last result for readback
`timescale 1ns/100ps

module apb_regs import ucs_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       psel_i,
    input  logic       penable_i,
    input  logic       pwrite_i,
    input  apb_addr_t  paddr_i,
    input  apb_data_t  pwdata_i,
    output apb_data_t  prdata_o,
    output logic       pready_o,
    output logic       pslverr_o,
    input  count_t     count_i,
    input  logic       full_i,
    input  logic       div_zero_i,
    input  clause_id_t rd_id_i,
    input  logic       rd_valid_i,
    input  slot_t      slot_i,
    output logic       push_o,
    output clause_id_t push_id_o,
    output logic       clear_o,
    output logic       clear_div_zero_o,
    output logic       start_o,
    output sel_req_t   req_o
);

    typedef enum logic {
        ST_IDLE,
        ST_WAIT
    } busy_state_t;

    busy_state_t state;
    logic [1:0]  busy_cnt;
    logic        busy;
    logic        access;
    logic        wr;
    logic        hit_ctrl, hit_push, hit_select, hit_status, hit_result;
    logic        unmapped;
    logic        result_valid;
    clause_id_t  result_id;
    slot_t       result_slot;
    slot_t       slot_q;

    // PREADY is tied high, so every access phase completes in one cycle
    assign access = psel_i && penable_i;
    assign wr = access && pwrite_i;
    assign pready_o = 1'b1;
    assign busy = (state == ST_WAIT);

    assign hit_ctrl = (paddr_i == REG_CTRL);
    assign hit_push = (paddr_i == REG_PUSH);
    assign hit_select = (paddr_i == REG_SELECT);
    assign hit_status = (paddr_i == REG_STATUS);
    assign hit_result = (paddr_i == REG_RESULT);
    assign unmapped = !(hit_ctrl || hit_push || hit_select || hit_status || hit_result);

    // Errors are only reported in the access phase
    assign pslverr_o = access && (unmapped || (pwrite_i && hit_push && full_i)
                       || (pwrite_i && hit_select && busy));

    // Side effects fire in the access cycle, and rejected writes have none
    assign push_o = wr && hit_push && !full_i;
    assign push_id_o = pwdata_i[CLAUSE_W-1:0];
    assign clear_o = wr && hit_ctrl && pwdata_i[0];
    assign clear_div_zero_o = wr && hit_ctrl && pwdata_i[1];
    assign start_o = wr && hit_select && !busy;
    assign req_o = '{rnd: pwdata_i[RAND_W-1:0], count: count_i};

    // Read mux, where control registers read back as zero
    always_comb begin
        prdata_o = '0;
        if (access && !pwrite_i) begin
            if (hit_status) begin
                prdata_o = {20'd0, full_i, div_zero_i, result_valid, busy, 2'd0, count_i};
            end else if (hit_result) begin
                prdata_o = {11'd0, result_slot, 4'd0, result_id};
            end
        end
    end

    // Busy covers the mapper latency plus the buffer read
    // The counter starts at MAP_LATENCY and leaves the wait state after it reaches zero
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state <= ST_IDLE;
            busy_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start_o) begin
                        state <= ST_WAIT;
                        busy_cnt <= 2'(MAP_LATENCY);
                    end
                end
                ST_WAIT: begin
                    if (busy_cnt == '0) begin
                        state <= ST_IDLE;
                    end else begin
                        busy_cnt <= busy_cnt - 2'd1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // The slot leaves the mapper one cycle before the buffer returns its identifier
    always_ff @(posedge clk_i) begin
        slot_q <= slot_i;
        if (rd_valid_i) begin
            result_id <= rd_id_i;
            result_slot <= slot_q;
        end
    end

    // A late read after a buffer clear refers to stale contents and is not reported
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            result_valid <= 1'b0;
        end else if (start_o || clear_o) begin
            result_valid <= 1'b0;
        end else if (rd_valid_i && count_i != '0) begin
            result_valid <= 1'b1;
        end
    end

endmodule

// ==== hw/clause_selector_top.sv ====
// Unsat-clause selector top level with the APB register block, mapper, table and buffer
`timescale 1ns/100ps

module clause_selector_top import ucs_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      psel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  apb_addr_t paddr_i,
    input  apb_data_t pwdata_i,
    output apb_data_t prdata_o,
    output logic      pready_o,
    output logic      pslverr_o
);

    logic       push, clear, clear_div_zero, start;
    clause_id_t push_id, rd_id;
    sel_req_t   req;
    logic       recip_en, div_zero, map_valid, rd_valid, full;
    count_t     recip_count, count;
    recip_t     recip;
    slot_t      map_slot;

    apb_regs i_apb_regs (
        .clk_i, .reset_i, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
        .prdata_o, .pready_o, .pslverr_o,
        .count_i(count), .full_i(full), .div_zero_i(div_zero), .rd_id_i(rd_id),
        .rd_valid_i(rd_valid), .slot_i(map_slot), .push_o(push), .push_id_o(push_id),
        .clear_o(clear), .clear_div_zero_o(clear_div_zero), .start_o(start), .req_o(req)
    );

    index_mapper i_index_mapper (
        .clk_i, .reset_i, .start_i(start), .req_i(req), .recip_en_o(recip_en),
        .recip_count_o(recip_count), .recip_i(recip), .slot_valid_o(map_valid),
        .slot_o(map_slot)
    );

    recip_table i_recip_table (
        .clk_i, .reset_i, .en_i(recip_en), .count_i(recip_count),
        .clear_div_zero_i(clear_div_zero), .recip_o(recip), .div_zero_o(div_zero)
    );

    unsat_buffer i_unsat_buffer (
        .clk_i, .reset_i, .push_i(push), .push_id_i(push_id), .clear_i(clear),
        .rd_en_i(map_valid), .rd_slot_i(map_slot), .rd_id_o(rd_id),
        .rd_valid_o(rd_valid), .count_o(count), .full_o(full)
    );

endmodule

// ==== testbench/clause_selector_sva.sv ====
// Bound checks on the APB error response and the selection busy window
`timescale 1ns/100ps

module clause_selector_sva import ucs_pkg::*; (
    input logic   clk_i,
    input logic   reset_i,
    input logic   psel_i,
    input logic   penable_i,
    input logic   pslverr_i,
    input logic   start_i,
    input logic   busy_i,
    input logic   result_valid_i,
    input count_t count_i
);

    // An error response only makes sense while the access phase is on the bus
    a_pslverr_access: assert property (@(posedge clk_i) disable iff (reset_i)
        pslverr_i |-> (psel_i && penable_i))
        else $error("pslverr raised outside the APB access phase");

    // Busy covers the four cycles that follow an accepted start
    a_busy_window: assert property (@(posedge clk_i) disable iff (reset_i)
        ($past(start_i, 1) || $past(start_i, 2) || $past(start_i, 3) || $past(start_i, 4))
        |-> busy_i)
        else $error("busy dropped inside the selection window");

    // The fifth cycle after a start is idle again
    a_busy_release: assert property (@(posedge clk_i) disable iff (reset_i)
        $past(start_i, 5) |-> !busy_i)
        else $error("busy still set five cycles after a start");

    // An empty buffer has no clause to report
    a_valid_nonempty: assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(result_valid_i) |-> (count_i != '0))
        else $error("result valid rose while the buffer count was zero");

endmodule

bind apb_regs clause_selector_sva i_clause_selector_sva (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .psel_i(psel_i),
    .penable_i(penable_i),
    .pslverr_i(pslverr_o),
    .start_i(start_o),
    .busy_i(busy),
    .result_valid_i(result_valid),
    .count_i(count_i)
);

// ==== testbench/clause_selector_tb.sv ====
// Table-driven APB testbench for the unsat-clause selector
// A queue model of the buffer predicts every slot as the random value modulo the count
`timescale 1ns/100ps

module clause_selector_tb import ucs_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_ROWS = 31;
    localparam int POLL_LIMIT = 8;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 20 + RESET_CYCLES;
    localparam logic [15:0] LFSR_SEED = 16'd30503;

    // Each row is a plain write, a plain read, a burst of pushes, a selection or a wait for idle
    typedef enum logic [2:0] {
        OP_WR,
        OP_RD,
        OP_PUSHN,
        OP_SEL,
        OP_WAIT
    } op_t;

    typedef struct packed {
        op_t       op;
        apb_addr_t addr;
        apb_data_t data;
        apb_data_t exp;
        logic      err;
    } row_t;

    logic       clk;
    logic       reset;
    logic       psel;
    logic       penable;
    logic       pwrite;
    apb_addr_t  paddr;
    apb_data_t  pwdata;
    apb_data_t  prdata;
    logic       pready;
    logic       pslverr;

    row_t       rows [NUM_ROWS];
    clause_id_t model_ids [$];
    logic [15:0] lfsr_state;
    int         check_errs;
    int         failed_rows;
    int         push_total;
    logic       pending;
    slot_t      exp_slot;
    clause_id_t exp_id;

    clause_selector_top i_clause_selector_top (
        .clk_i(clk),
        .reset_i(reset),
        .psel_i(psel),
        .penable_i(penable),
        .pwrite_i(pwrite),
        .paddr_i(paddr),
        .pwdata_i(pwdata),
        .prdata_o(prdata),
        .pready_o(pready),
        .pslverr_o(pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Taps 16, 14, 13 and 11 give a maximal-length sequence
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit of the random value
    task automatic draw_random(output rand_t r);
        r = '0;
        for (int b = 0; b < RAND_W; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[RAND_W-2:0], lfsr_state[0]};
        end
    endtask

    // Setup cycle, access cycle, then release, with outputs sampled mid access cycle
    task automatic apb_transfer(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                                output apb_data_t rdata, output logic err);
        @(posedge clk);
        #DRIVE_DELAY;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = write;
        paddr = addr;
        pwdata = wdata;
        @(posedge clk);
        #DRIVE_DELAY;
        penable = 1'b1;
        @(negedge clk);
        rdata = prdata;
        err = pslverr;
        // The slave never inserts wait states
        check_value("pready_o", 32'(pready), 32'd1);
        @(posedge clk);
        #DRIVE_DELAY;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic write_reg(input apb_addr_t addr, input apb_data_t data, output logic err);
        apb_data_t unused;
        apb_transfer(1'b1, addr, data, unused, err);
    endtask

    task automatic read_reg(input apb_addr_t addr, output apb_data_t data, output logic err);
        apb_transfer(1'b0, addr, '0, data, err);
    endtask

    task automatic check_value(input string name, input apb_data_t got, input apb_data_t exp);
        assert (got === exp) else begin
            $display("mismatch at %0t ns: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
            check_errs++;
        end
    endtask

    // Polls STATUS until the busy bit drops, giving up after a bounded number of reads
    task automatic wait_idle(output apb_data_t status);
        apb_data_t st;
        logic      err;
        int        polls;
        polls = 0;
        read_reg(REG_STATUS, st, err);
        while (st[8] && polls < POLL_LIMIT) begin
            read_reg(REG_STATUS, st, err);
            polls++;
        end
        assert (!st[8]) else begin
            $display("selection still busy after %0d status polls at %0t ns", POLL_LIMIT, $time);
            check_errs++;
        end
        status = st;
    endtask

    task automatic run_row(input row_t r);
        apb_data_t  rdata;
        logic       err;
        rand_t      rnd;
        clause_id_t id;
        case (r.op)
            OP_WR: begin
                write_reg(r.addr, r.data, err);
                check_value("pslverr_o", 32'(err), 32'(r.err));
                if (!r.err && r.addr == REG_PUSH) begin
                    model_ids.push_back(r.data[CLAUSE_W-1:0]);
                end
                if (!r.err && r.addr == REG_CTRL && r.data[0]) begin
                    model_ids.delete();
                    pending = 1'b0;
                end
            end
            OP_RD: begin
                read_reg(r.addr, rdata, err);
                check_value("prdata_o", rdata, r.exp);
                check_value("pslverr_o", 32'(err), 32'(r.err));
            end
            OP_PUSHN: begin
                for (int k = 0; k < r.data; k++) begin
                    id = clause_id_t'(push_total * 157 + 'h3A5);
                    push_total++;
                    write_reg(REG_PUSH, {20'd0, id}, err);
                    check_value("pslverr_o", 32'(err), 32'd0);
                    model_ids.push_back(id);
                    // The count must follow every single push
                    read_reg(REG_STATUS, rdata, err);
                    check_value("status count", 32'(rdata[5:0]), model_ids.size());
                    check_value("status full", 32'(rdata[11]), 32'(model_ids.size() == BUF_DEPTH));
                end
            end
            OP_SEL: begin
                draw_random(rnd);
                write_reg(REG_SELECT, {16'd0, rnd}, err);
                check_value("pslverr_o", 32'(err), 32'(r.err));
                // A rejected select leaves the earlier prediction in place
                if (!r.err) begin
                    pending = (model_ids.size() != 0);
                    if (pending) begin
                        exp_slot = slot_t'(int'(rnd) % model_ids.size());
                        exp_id = model_ids[exp_slot];
                    end
                end
            end
            OP_WAIT: begin
                wait_idle(rdata);
                check_value("status result_valid", 32'(rdata[9]), 32'(pending));
                if (pending) begin
                    read_reg(REG_RESULT, rdata, err);
                    check_value("prdata_o", rdata, {11'd0, exp_slot, 4'd0, exp_id});
                end
            end
            default: begin
            end
        endcase
    endtask

    // Fill count first, then selections on partial and full buffers, then error and clear cases
    task automatic load_table();
        rows[0]  = '{OP_RD,    REG_STATUS, 32'h0,   32'h0,   1'b0};
        rows[1]  = '{OP_PUSHN, REG_PUSH,   32'd5,   32'h0,   1'b0};
        rows[2]  = '{OP_SEL,   REG_SELECT, 32'h0,   32'h0,   1'b0};
        rows[3]  = '{OP_WAIT,  REG_STATUS, 32'h0,   32'h0,   1'b0};
        rows[4]  = '{OP_SEL,   REG_SELECT, 32'h0,   32'h0,   1'b0};
        rows[5]  = '{OP_WAIT,  REG_STATUS, 32'h0,   32'h0,   1'b0};
        rows[6]  = '{OP_PUSHN, REG_PUSH,   32'd27,  32'h0,   1'b0};
        rows[7]  = '{OP_WR,    REG_PUSH,   32'hABC, 32'h0,   1'b1};
        rows[8]  = '{OP_RD,    REG_STATUS, 32'h0,   32'hA20, 1'b0};
        rows[9]  = '{OP_SEL,   REG_SELECT, 32'h0,   32'h0,   1'b0};
        rows[10] = '{OP_SEL,   REG_SELECT, 32'h0,   32'h0,   1'b1};
        rows[11] = '{OP_WAIT,  REG_STATUS, 32'h0,   32'h0,   1'b0};
        rows[12] = '{OP_SEL,   REG_SELECT, 32'h0,   32'h0,   1'b0};
        rows[13] = '{OP_WAIT,  REG_STATUS, 32'h0,   32'h0,   1'b0};
        rows[14] = '{OP_SEL,   REG_SELECT, 32'h0,   32'h0,   1'b0};
        rows[15] = '{OP_WAIT,  REG_STATUS, 32'h0,   32'h0,   1'b0};
        rows[16] = '{OP_WR,    REG_CTRL,   32'h1,   32'h0,   1'b0};
        rows[17] = '{OP_RD,    REG_STATUS, 32'h0,   32'h0,   1'b0};
        rows[18] = '{OP_SEL,   REG_SELECT, 32'h0,   32'h0,   1'b0};
        rows[19] = '{OP_WAIT,  REG_STATUS, 32'h0,   32'h0,   1'b0};
        rows[20] = '{OP_RD,    REG_STATUS, 32'h0,   32'h400, 1'b0};
        rows[21] = '{OP_WR,    REG_CTRL,   32'h2,   32'h0,   1'b0};
        rows[22] = '{OP_RD,    REG_STATUS, 32'h0,   32'h0,   1'b0};
        rows[23] = '{OP_RD,    8'h14,      32'h0,   32'h0,   1'b1};
        rows[24] = '{OP_WR,    8'h20,      32'h5,   32'h0,   1'b1};
        rows[25] = '{OP_PUSHN, REG_PUSH,   32'd1,   32'h0,   1'b0};
        rows[26] = '{OP_SEL,   REG_SELECT, 32'h0,   32'h0,   1'b0};
        rows[27] = '{OP_WAIT,  REG_STATUS, 32'h0,   32'h0,   1'b0};
        rows[28] = '{OP_PUSHN, REG_PUSH,   32'd2,   32'h0,   1'b0};
        rows[29] = '{OP_SEL,   REG_SELECT, 32'h0,   32'h0,   1'b0};
        rows[30] = '{OP_WAIT,  REG_STATUS, 32'h0,   32'h0,   1'b0};
    endtask

    // Budget of twenty cycles per row on top of the reset time
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles with rows still running", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        int  errs_before;
        op_t op_now;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        reset = 1'b1;
        check_errs = 0;
        failed_rows = 0;
        push_total = 0;
        pending = 1'b0;
        exp_slot = '0;
        exp_id = '0;
        lfsr_state = LFSR_SEED;
        load_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            errs_before = check_errs;
            op_now = rows[i].op;
            run_row(rows[i]);
            if (check_errs != errs_before) begin
                failed_rows++;
            end
            $display("row %0d %s %s", i, op_now.name(),
                     (check_errs == errs_before) ? "ok" : "failed");
        end
        $display("rows %0d, failed rows %0d, failed checks %0d", NUM_ROWS, failed_rows, check_errs);
        if (check_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== hw/recip_table.mem ====
FFFFFFFF
80000000
55555556
40000000
33333334
2AAAAAAB
24924925
20000000
1C71C71D
1999999A
1745D175
15555556
13B13B14
12492493
11111112
10000000
0F0F0F10
0E38E38F
0D79435F
0CCCCCCD
0C30C30D
0BA2E8BB
0B21642D
0AAAAAAB
0A3D70A4
09D89D8A
097B425F
0924924A
08D3DCB1
08888889
08421085
08000000

// ==== compile.f ====
hw/ucs_pkg.sv
hw/recip_table.sv
hw/unsat_buffer.sv
hw/index_mapper.sv
hw/apb_regs.sv
hw/clause_selector_top.sv
testbench/clause_selector_sva.sv
testbench/clause_selector_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the selector testbench with Verilator, runs it and checks the log for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module clause_selector_tb \
    -f compile.f -o clause_selector_sim > build.log 2>&1 \
    || { cat build.log; exit 1; }

./obj_dir/clause_selector_sim > sim.log 2>&1
cat sim.log

grep -q "^RESULT: PASS$" sim.log && exit 0 || exit 1
